// File: fb_pkg.sv
`default_nettype none

package fb_pkg;

  // ------------------------------
  // data widths
  typedef logic [15:0] pixel_t;
  typedef logic [63:0] word_t;
  typedef logic [29:0] addr_t;   // byte address on the memory port
  typedef logic [1:0]  bank_t;

  localparam int PIXELS_PER_WORD = 4;   // pixel 0 in the low bits
  localparam int BYTES_PER_WORD  = 8;
  localparam int NUM_BANKS       = 4;

  // ------------------------------
  // burst command to the memory port
  typedef struct packed {
    logic       is_write;
    addr_t      addr;
    logic [7:0] len;   // words per burst
  } burst_cmd_t;

endpackage

`default_nettype wire

// File: sync_fifo.sv
`default_nettype none

module sync_fifo #(
  parameter type item_t = logic [7:0],
  parameter int  DEPTH  = 16
) (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       push,
  input  item_t                      push_data,
  input  logic                       pop,
  output item_t                      pop_data,
  output logic                       empty,
  output logic [$clog2(DEPTH+1)-1:0] count
);

  localparam int AW = $clog2(DEPTH);

  item_t         mem [DEPTH];
  logic [AW-1:0] wr_ptr;
  logic [AW-1:0] rd_ptr;

  assign pop_data = mem[rd_ptr];   // head word always visible
  assign empty    = (count == '0);

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= push_data;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // ------------------------------
  // callers must respect fill level
  assert property (@(posedge clk) disable iff (!rst_n) push |-> (count != DEPTH))
    else $error("sync_fifo: push while full");
  assert property (@(posedge clk) disable iff (!rst_n) pop |-> !empty)
    else $error("sync_fifo: pop while empty");

endmodule

`default_nettype wire

// File: frame_writer.sv
`default_nettype none

module frame_writer #(
  parameter int            BURST_LEN   = 4,
  parameter int            FRAME_WORDS = 16,
  parameter int            FIFO_DEPTH  = 16,
  parameter fb_pkg::addr_t BASE_ADDR   = '0
) (
  input  logic               clk,
  input  logic               rst_n,
  input  fb_pkg::pixel_t     pix_in,
  input  logic               pix_in_valid,
  output logic               req,
  output fb_pkg::burst_cmd_t cmd,
  input  logic               grant,
  input  logic               done,
  input  logic               wr_req,
  output fb_pkg::word_t      wr_data,
  output fb_pkg::bank_t      bank,
  output logic               frames_ready
);

  import fb_pkg::*;

  localparam int PW = $bits(pixel_t);
  localparam int SW = $clog2(PIXELS_PER_WORD);
  localparam int WW = $clog2(FRAME_WORDS);
  localparam int CW = $clog2(FIFO_DEPTH + 1);

  logic [SW-1:0] pack_cnt;
  word_t         pack_buf;
  word_t         pack_word;
  logic          fifo_push;
  logic          fifo_pop;
  logic          fifo_empty;
  logic [CW-1:0] fifo_count;
  logic [WW-1:0] word_idx;     // word offset inside the bank
  logic          last_burst;

  // ------------------------------
  // pixel packing
  always_comb begin
    pack_word = pack_buf;
    pack_word[pack_cnt*PW +: PW] = pix_in;
  end

  assign fifo_push = pix_in_valid && (pack_cnt == SW'(PIXELS_PER_WORD - 1));

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pack_cnt <= '0;
    end else if (pix_in_valid) begin
      pack_cnt <= fifo_push ? '0 : pack_cnt + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (pix_in_valid) begin
      pack_buf <= pack_word;
    end
  end

  sync_fifo #(
    .item_t (word_t),
    .DEPTH  (FIFO_DEPTH)
  ) u_wr_fifo (
    .clk       (clk),
    .rst_n     (rst_n),
    .push      (fifo_push),
    .push_data (pack_word),
    .pop       (fifo_pop),
    .pop_data  (wr_data),
    .empty     (fifo_empty),
    .count     (fifo_count)
  );

  assign fifo_pop = wr_req && grant && !fifo_empty;
  assign req      = (fifo_count >= BURST_LEN);   // a full burst is buffered

  // ------------------------------
  // address and bank stepping
  assign last_burst = (int'(word_idx) + BURST_LEN >= FRAME_WORDS);

  assign cmd = '{
    is_write: 1'b1,
    addr:     addr_t'(BASE_ADDR +
                      (int'(bank) * FRAME_WORDS + int'(word_idx)) * BYTES_PER_WORD),
    len:      8'(BURST_LEN)
  };

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      word_idx     <= '0;
      bank         <= '0;
      frames_ready <= 1'b0;
    end else if (done) begin
      if (last_burst) begin
        word_idx <= '0;
        bank     <= (bank == bank_t'(NUM_BANKS - 1)) ? '0 : bank + 1'b1;
      end else begin
        word_idx <= word_idx + WW'(BURST_LEN);
      end
      if (bank == bank_t'(NUM_BANKS - 1)) begin
        frames_ready <= 1'b1;   // sticky until reset
      end
    end
  end

endmodule

`default_nettype wire

// File: frame_reader.sv
`default_nettype none

module frame_reader #(
  parameter int            BURST_LEN   = 4,
  parameter int            FRAME_WORDS = 16,
  parameter int            FIFO_DEPTH  = 16,
  parameter fb_pkg::addr_t BASE_ADDR   = '0,
  parameter int            START_BANK  = 0
) (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               enable,
  input  fb_pkg::bank_t      block_bank,
  output logic               req,
  output fb_pkg::burst_cmd_t cmd,
  input  logic               grant,
  input  logic               done,
  input  logic               rd_vld,
  input  fb_pkg::word_t      rd_data,
  output fb_pkg::bank_t      bank,
  input  logic               pix_req,
  output fb_pkg::pixel_t     pix,
  output logic               pix_valid
);

  import fb_pkg::*;

  localparam int PW = $bits(pixel_t);
  localparam int SW = $clog2(PIXELS_PER_WORD);
  localparam int WW = $clog2(FRAME_WORDS);
  localparam int CW = $clog2(FIFO_DEPTH + 1);

  logic [WW-1:0] word_idx;
  logic          last_burst;
  bank_t         next_bank;
  logic          grant_q;
  logic          grant_rise;
  logic [CW-1:0] inflight;     // words granted but not yet arrived
  logic [CW:0]   reserved;
  logic          fifo_push;
  logic          fifo_pop;
  word_t         fifo_data;
  logic          fifo_empty;
  logic [CW-1:0] fifo_count;
  word_t         hold_word;
  logic [SW-1:0] slot;
  logic          take;

  // ------------------------------
  // burst requests
  assign grant_rise = grant && !grant_q;
  assign fifo_push  = rd_vld && grant;
  assign reserved   = {1'b0, fifo_count} + {1'b0, inflight};
  assign req        = enable && (int'(reserved) <= FIFO_DEPTH - BURST_LEN);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      grant_q  <= 1'b0;
      inflight <= '0;
    end else begin
      grant_q  <= grant;
      inflight <= inflight + (grant_rise ? CW'(BURST_LEN) : CW'(0))
                           - (fifo_push ? CW'(1) : CW'(0));
    end
  end

  // ------------------------------
  // address with advance-or-reread
  assign last_burst = (int'(word_idx) + BURST_LEN >= FRAME_WORDS);
  assign next_bank  = (bank == bank_t'(NUM_BANKS - 1)) ? '0 : bank + 1'b1;

  assign cmd = '{
    is_write: 1'b0,
    addr:     addr_t'(BASE_ADDR +
                      (int'(bank) * FRAME_WORDS + int'(word_idx)) * BYTES_PER_WORD),
    len:      8'(BURST_LEN)
  };

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      word_idx <= '0;
      bank     <= bank_t'(START_BANK);
    end else if (done) begin
      if (last_burst) begin
        word_idx <= '0;
        if (next_bank != block_bank) begin
          bank <= next_bank;   // otherwise same bank again
        end
      end else begin
        word_idx <= word_idx + WW'(BURST_LEN);
      end
    end
  end

  sync_fifo #(
    .item_t (word_t),
    .DEPTH  (FIFO_DEPTH)
  ) u_rd_fifo (
    .clk       (clk),
    .rst_n     (rst_n),
    .push      (fifo_push),
    .push_data (rd_data),
    .pop       (fifo_pop),
    .pop_data  (fifo_data),
    .empty     (fifo_empty),
    .count     (fifo_count)
  );

  // ------------------------------
  // unpacker, lowest pixel first
  assign pix      = hold_word[slot*PW +: PW];
  assign take     = pix_req && pix_valid;
  assign fifo_pop = !fifo_empty &&
                    (!pix_valid || (take && slot == SW'(PIXELS_PER_WORD - 1)));

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pix_valid <= 1'b0;
      slot      <= '0;
    end else if (fifo_pop) begin
      pix_valid <= 1'b1;
      slot      <= '0;
    end else if (take) begin
      if (slot == SW'(PIXELS_PER_WORD - 1)) begin
        pix_valid <= 1'b0;   // word drained, fifo empty
      end
      slot <= slot + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (fifo_pop) begin
      hold_word <= fifo_data;
    end
  end

  // read data only against a reserved burst
  assert property (@(posedge clk) disable iff (!rst_n) fifo_push |-> (inflight != '0))
    else $error("frame_reader: read word outside a granted burst");

endmodule

`default_nettype wire

// File: burst_arbiter.sv
`default_nettype none

module burst_arbiter (
  input  logic               clk,
  input  logic               rst_n,
  // writer
  input  logic               w_req,
  input  fb_pkg::burst_cmd_t w_cmd,
  output logic               w_grant,
  output logic               w_done,
  output logic               w_wr_req,
  input  fb_pkg::word_t      w_wr_data,
  // current frame reader
  input  logic               c_req,
  input  fb_pkg::burst_cmd_t c_cmd,
  output logic               c_grant,
  output logic               c_done,
  // previous frame reader
  input  logic               p_req,
  input  fb_pkg::burst_cmd_t p_cmd,
  output logic               p_grant,
  output logic               p_done,
  output logic               rd_vld,
  output fb_pkg::word_t      rd_data,
  // memory port
  output fb_pkg::burst_cmd_t mem_cmd,
  output logic               mem_cmd_start,
  input  logic               mem_busy,
  input  logic               mem_done,
  input  logic               mem_wr_req,
  output fb_pkg::word_t      mem_wr_data,
  input  logic               mem_rd_vld,
  input  fb_pkg::word_t      mem_rd_data
);

  import fb_pkg::*;

  typedef enum logic [1:0] {
    OWN_NONE,
    OWN_W,
    OWN_C,
    OWN_P
  } owner_t;

  owner_t owner;
  owner_t pick;
  logic   rd_turn;   // 0 current, 1 previous

  // writes first, reads take turns
  always_comb begin
    pick = OWN_NONE;
    if (owner == OWN_NONE && !mem_busy) begin
      if (w_req) begin
        pick = OWN_W;
      end else if (!rd_turn && c_req) begin
        pick = OWN_C;
      end else if (rd_turn && p_req) begin
        pick = OWN_P;
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      owner         <= OWN_NONE;
      rd_turn       <= 1'b0;
      mem_cmd_start <= 1'b0;
    end else begin
      mem_cmd_start <= (pick != OWN_NONE);
      if (pick != OWN_NONE) begin
        owner <= pick;
      end else if (mem_done && owner != OWN_NONE) begin
        owner <= OWN_NONE;
        if (owner != OWN_W) begin
          rd_turn <= !rd_turn;   // flip on each read burst
        end
      end
    end
  end

  // ------------------------------
  // routing to the owner
  assign w_grant = (owner == OWN_W);
  assign c_grant = (owner == OWN_C);
  assign p_grant = (owner == OWN_P);

  always_comb begin
    case (owner)
      OWN_C:   mem_cmd = c_cmd;
      OWN_P:   mem_cmd = p_cmd;
      default: mem_cmd = w_cmd;
    endcase
  end

  assign w_done      = mem_done && w_grant;
  assign c_done      = mem_done && c_grant;
  assign p_done      = mem_done && p_grant;
  assign w_wr_req    = mem_wr_req && w_grant;
  assign mem_wr_data = w_wr_data;
  assign rd_vld      = mem_rd_vld && (c_grant || p_grant);
  assign rd_data     = mem_rd_data;

  assert property (@(posedge clk) disable iff (!rst_n) mem_done |-> (owner != OWN_NONE))
    else $error("burst_arbiter: burst done with no burst granted");
  assert property (@(posedge clk) disable iff (!rst_n) mem_rd_vld |-> (c_grant || p_grant))
    else $error("burst_arbiter: read data with no reader granted");

endmodule

`default_nettype wire

// File: fb_top.sv
`default_nettype none

module fb_top #(
  parameter int            BURST_LEN   = 4,
  parameter int            FRAME_WORDS = 16,
  parameter int            FIFO_DEPTH  = 16,
  parameter fb_pkg::addr_t BASE_ADDR   = '0
) (
  input  logic               clk,
  input  logic               rst_n,
  input  fb_pkg::pixel_t     pix_in,
  input  logic               pix_in_valid,
  input  logic               pix_req,
  output fb_pkg::pixel_t     cur_pix,
  output logic               cur_pix_valid,
  output fb_pkg::pixel_t     prev_pix,
  output logic               prev_pix_valid,
  output logic               frames_ready,
  output fb_pkg::burst_cmd_t mem_cmd,
  output logic               mem_cmd_start,
  input  logic               mem_busy,
  input  logic               mem_done,
  input  logic               mem_wr_req,
  output fb_pkg::word_t      mem_wr_data,
  input  logic               mem_rd_vld,
  input  fb_pkg::word_t      mem_rd_data
);

  import fb_pkg::*;

  logic       w_req;
  burst_cmd_t w_cmd;
  logic       w_grant;
  logic       w_done;
  logic       w_wr_req;
  word_t      w_wr_data;
  bank_t      w_bank;
  logic       c_req;
  burst_cmd_t c_cmd;
  logic       c_grant;
  logic       c_done;
  bank_t      c_bank;
  logic       p_req;
  burst_cmd_t p_cmd;
  logic       p_grant;
  logic       p_done;
  logic       rd_vld;     // shared by both readers
  word_t      rd_data;

  frame_writer #(
    .BURST_LEN   (BURST_LEN),
    .FRAME_WORDS (FRAME_WORDS),
    .FIFO_DEPTH  (FIFO_DEPTH),
    .BASE_ADDR   (BASE_ADDR)
  ) u_writer (
    .clk          (clk),
    .rst_n        (rst_n),
    .pix_in       (pix_in),
    .pix_in_valid (pix_in_valid),
    .req          (w_req),
    .cmd          (w_cmd),
    .grant        (w_grant),
    .done         (w_done),
    .wr_req       (w_wr_req),
    .wr_data      (w_wr_data),
    .bank         (w_bank),
    .frames_ready (frames_ready)
  );

  // ------------------------------
  // readers, current blocked by writer
  frame_reader #(
    .BURST_LEN   (BURST_LEN),
    .FRAME_WORDS (FRAME_WORDS),
    .FIFO_DEPTH  (FIFO_DEPTH),
    .BASE_ADDR   (BASE_ADDR),
    .START_BANK  (1)
  ) u_cur_reader (
    .clk        (clk),
    .rst_n      (rst_n),
    .enable     (frames_ready),
    .block_bank (w_bank),
    .req        (c_req),
    .cmd        (c_cmd),
    .grant      (c_grant),
    .done       (c_done),
    .rd_vld     (rd_vld),
    .rd_data    (rd_data),
    .bank       (c_bank),
    .pix_req    (pix_req),
    .pix        (cur_pix),
    .pix_valid  (cur_pix_valid)
  );

  frame_reader #(
    .BURST_LEN   (BURST_LEN),
    .FRAME_WORDS (FRAME_WORDS),
    .FIFO_DEPTH  (FIFO_DEPTH),
    .BASE_ADDR   (BASE_ADDR),
    .START_BANK  (0)
  ) u_prev_reader (
    .clk        (clk),
    .rst_n      (rst_n),
    .enable     (frames_ready),
    .block_bank (c_bank),        // trails the current reader
    .req        (p_req),
    .cmd        (p_cmd),
    .grant      (p_grant),
    .done       (p_done),
    .rd_vld     (rd_vld),
    .rd_data    (rd_data),
    .bank       (),
    .pix_req    (pix_req),
    .pix        (prev_pix),
    .pix_valid  (prev_pix_valid)
  );

  burst_arbiter u_arbiter (
    .clk           (clk),
    .rst_n         (rst_n),
    .w_req         (w_req),
    .w_cmd         (w_cmd),
    .w_grant       (w_grant),
    .w_done        (w_done),
    .w_wr_req      (w_wr_req),
    .w_wr_data     (w_wr_data),
    .c_req         (c_req),
    .c_cmd         (c_cmd),
    .c_grant       (c_grant),
    .c_done        (c_done),
    .p_req         (p_req),
    .p_cmd         (p_cmd),
    .p_grant       (p_grant),
    .p_done        (p_done),
    .rd_vld        (rd_vld),
    .rd_data       (rd_data),
    .mem_cmd       (mem_cmd),
    .mem_cmd_start (mem_cmd_start),
    .mem_busy      (mem_busy),
    .mem_done      (mem_done),
    .mem_wr_req    (mem_wr_req),
    .mem_wr_data   (mem_wr_data),
    .mem_rd_vld    (mem_rd_vld),
    .mem_rd_data   (mem_rd_data)
  );

endmodule

`default_nettype wire

// File: fb_tb.sv
`default_nettype none

module fb_tb;

  timeunit 1ns;
  timeprecision 1ps;

  import fb_pkg::*;

  localparam int BURST_LEN   = 4;
  localparam int FRAME_WORDS = 16;
  localparam int MEM_WORDS   = NUM_BANKS * FRAME_WORDS;
  localparam int PW          = $bits(pixel_t);
  localparam int PIX_TARGET  = 200;     // pixels per stream
  localparam int RUN_LIMIT   = 40000;   // cycles
  localparam int IDLE_LIMIT  = 3000;    // cycles with no command

  logic       clk;
  logic       rst_n;
  pixel_t     pix_in;
  logic       pix_in_valid;
  logic       pix_req;
  pixel_t     cur_pix;
  logic       cur_pix_valid;
  pixel_t     prev_pix;
  logic       prev_pix_valid;
  logic       frames_ready;
  burst_cmd_t mem_cmd;
  logic       mem_cmd_start;
  logic       mem_busy;
  logic       mem_done;
  logic       mem_wr_req;
  word_t      mem_wr_data;
  logic       mem_rd_vld;
  word_t      mem_rd_data;

  integer     seed;
  word_t      mem_model [MEM_WORDS];
  pixel_t     in_q [$];     // pixels sent, not yet seen in a write word
  pixel_t     cur_q [$];    // pixels read for the current stream
  pixel_t     prev_q [$];

  // ------------------------------
  // memory model and reference state
  int         mstate;       // 0 idle, 1 latency, 2 data, 3 done
  int         lat_cnt;
  int         beat;
  int         owner;        // 0 writer, 1 current, 2 previous
  burst_cmd_t act_cmd;
  int         w_bank;
  int         w_idx;
  int         c_bank;
  int         c_idx;
  int         p_bank;
  int         p_idx;
  logic       rd_turn;      // 0 current, 1 previous
  logic       exp_ready;
  int         cur_cnt;
  int         prev_cnt;
  int         cycles;
  int         idle_cycles;

  fb_top u_fb_top (
    .clk            (clk),
    .rst_n          (rst_n),
    .pix_in         (pix_in),
    .pix_in_valid   (pix_in_valid),
    .pix_req        (pix_req),
    .cur_pix        (cur_pix),
    .cur_pix_valid  (cur_pix_valid),
    .prev_pix       (prev_pix),
    .prev_pix_valid (prev_pix_valid),
    .frames_ready   (frames_ready),
    .mem_cmd        (mem_cmd),
    .mem_cmd_start  (mem_cmd_start),
    .mem_busy       (mem_busy),
    .mem_done       (mem_done),
    .mem_wr_req     (mem_wr_req),
    .mem_wr_data    (mem_wr_data),
    .mem_rd_vld     (mem_rd_vld),
    .mem_rd_data    (mem_rd_data)
  );

  always #50 clk = ~clk;   // 100 ns period

  task automatic stop_run();
    $display("FAIL: see errors above");
    $fatal(1, "simulation stopped at first error");
  endtask

  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    if (expected !== actual) begin
      $display("FAIL %0s: expected %0h actual %0h", name, expected, actual);
      stop_run();
    end
  endtask

  task automatic report_error(input string msg);
    $display("ERROR: %0s", msg);
    stop_run();
  endtask

  function automatic addr_t bank_addr(input int bank, input int idx);
    return addr_t'((bank * FRAME_WORDS + idx) * BYTES_PER_WORD);   // base address 0
  endfunction

  function automatic int step_idx(input int idx);
    return (idx + BURST_LEN >= FRAME_WORDS) ? 0 : idx + BURST_LEN;
  endfunction

  // bank after a burst, stays put when the next bank is blocked
  function automatic int step_bank(input int bank, input int idx, input int block);
    int nb;
    nb = (bank + 1) % NUM_BANKS;
    if (idx + BURST_LEN < FRAME_WORDS || nb == block) begin
      return bank;
    end
    return nb;
  endfunction

  // ------------------------------
  // burst memory, one step per falling edge
  task automatic memory_step();
    int    widx;
    int    k;
    word_t exp_word;
    mem_done   = 1'b0;
    mem_wr_req = 1'b0;
    mem_rd_vld = 1'b0;
    if (mem_cmd_start) begin
      if (mstate != 0) begin
        report_error("command started while a burst was still running");
      end
      act_cmd = mem_cmd;
      if (mem_cmd.is_write) begin
        owner = 0;
        check_value("write address", bank_addr(w_bank, w_idx), mem_cmd.addr);
      end else begin
        check_value("read before frames_ready", 1, frames_ready);
        owner = rd_turn ? 2 : 1;
        if (rd_turn) begin
          check_value("previous read address", bank_addr(p_bank, p_idx), mem_cmd.addr);
        end else begin
          check_value("current read address", bank_addr(c_bank, c_idx), mem_cmd.addr);
        end
      end
      check_value("burst length", BURST_LEN, mem_cmd.len);
      mem_busy    = 1'b1;
      lat_cnt     = 1 + ($random(seed) & 3);   // 1 to 4 cycles
      mstate      = 1;
      idle_cycles = 0;
    end else begin
      case (mstate)
        1: begin
          if (lat_cnt > 1) begin
            lat_cnt--;
          end else begin
            mstate = 2;
            beat   = 0;
          end
        end
        2: begin
          widx = int'(act_cmd.addr) / BYTES_PER_WORD + beat;
          if (widx >= MEM_WORDS) begin
            report_error("burst address outside the memory model");
          end
          if (owner == 0) begin
            if (in_q.size() < PIXELS_PER_WORD) begin
              report_error("write word requested before four pixels were sent");
            end
            for (k = 0; k < PIXELS_PER_WORD; k++) begin
              exp_word[k*PW +: PW] = in_q.pop_front();   // pixel 0 lowest
            end
            check_value("write data", exp_word, mem_wr_data);
            mem_model[widx] = mem_wr_data;
            mem_wr_req      = 1'b1;
          end else begin
            mem_rd_data = mem_model[widx];
            mem_rd_vld  = 1'b1;
            for (k = 0; k < PIXELS_PER_WORD; k++) begin
              if (owner == 1) begin
                cur_q.push_back(mem_model[widx][k*PW +: PW]);
              end else begin
                prev_q.push_back(mem_model[widx][k*PW +: PW]);
              end
            end
          end
          beat++;
          if (beat == BURST_LEN) begin
            mstate = 3;
          end
        end
        3: begin
          mem_done = 1'b1;
          mem_busy = 1'b0;
          if (owner == 0) begin
            if (w_bank == NUM_BANKS - 1) begin
              exp_ready = 1'b1;
            end
            w_bank = step_bank(w_bank, w_idx, -1);   // writer never blocked
            w_idx  = step_idx(w_idx);
          end else if (owner == 1) begin
            c_bank = step_bank(c_bank, c_idx, w_bank);
            c_idx  = step_idx(c_idx);
          end else begin
            p_bank = step_bank(p_bank, p_idx, c_bank);
            p_idx  = step_idx(p_idx);
          end
          if (owner != 0) begin
            rd_turn = !rd_turn;
          end
          mstate = 0;
        end
        default: idle_cycles++;
      endcase
    end
  endtask

  // ------------------------------
  // pixel streams in and out
  task automatic pixel_step();
    pixel_t exp_pix;
    pix_req = (($random(seed) & 3) != 0);   // about 3 in 4
    if (pix_req && cur_pix_valid) begin
      if (cur_q.size() == 0) begin
        report_error("current stream gave a pixel that memory never returned");
      end
      exp_pix = cur_q.pop_front();
      check_value("current pixel", exp_pix, cur_pix);
      cur_cnt++;
    end
    if (pix_req && prev_pix_valid) begin
      if (prev_q.size() == 0) begin
        report_error("previous stream gave a pixel that memory never returned");
      end
      exp_pix = prev_q.pop_front();
      check_value("previous pixel", exp_pix, prev_pix);
      prev_cnt++;
    end
    pix_in_valid = (($random(seed) & 3) == 0);   // about 1 in 4
    pix_in       = pixel_t'($random(seed));
    if (pix_in_valid) begin
      in_q.push_back(pix_in);
    end
  endtask

  initial begin
    int i;
    clk          = 1'b0;
    rst_n        = 1'b0;
    pix_in       = '0;
    pix_in_valid = 1'b0;
    pix_req      = 1'b0;
    mem_busy     = 1'b0;
    mem_done     = 1'b0;
    mem_wr_req   = 1'b0;
    mem_rd_vld   = 1'b0;
    mem_rd_data  = '0;
    seed         = 52446;
    mstate       = 0;
    lat_cnt      = 0;
    beat         = 0;
    owner        = 0;
    act_cmd      = '0;
    w_bank       = 0;
    w_idx        = 0;
    c_bank       = 1;
    c_idx        = 0;
    p_bank       = 0;
    p_idx        = 0;
    rd_turn      = 1'b0;
    exp_ready    = 1'b0;
    cur_cnt      = 0;
    prev_cnt     = 0;
    cycles       = 0;
    idle_cycles  = 0;
    for (i = 0; i < MEM_WORDS; i++) begin
      mem_model[i] = word_t'(i + 1) * 64'h9e37_79b9_7f4a_7c15;   // unwritten words differ
    end

    repeat (3) @(negedge clk);
    check_value("start pulse in reset", 0, mem_cmd_start);
    check_value("frames_ready in reset", 0, frames_ready);
    rst_n = 1'b1;
    @(negedge clk);
    check_value("start pulse after reset", 0, mem_cmd_start);
    check_value("frames_ready after reset", 0, frames_ready);
    check_value("current valid after reset", 0, cur_pix_valid);
    check_value("previous valid after reset", 0, prev_pix_valid);

    while (cur_cnt < PIX_TARGET || prev_cnt < PIX_TARGET) begin
      check_value("frames_ready", exp_ready, frames_ready);
      memory_step();
      pixel_step();
      cycles++;
      if (cycles > RUN_LIMIT) begin
        report_error("timeout before both streams delivered 200 pixels");
      end
      if (idle_cycles > IDLE_LIMIT) begin
        report_error("timeout with no command on the memory port");
      end
      @(negedge clk);
    end
    $display("PASS: all tests");
    $finish;
  end

endmodule

`default_nettype wire

// File: compile.f
fb_pkg.sv
sync_fifo.sv
frame_writer.sv
frame_reader.sv
burst_arbiter.sv
fb_top.sv
fb_tb.sv

// File: run.sh
#!/usr/bin/env bash
# builds the testbench with Verilator, runs it and looks for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
  -f compile.f --top-module fb_tb -o fb_tb_sim \
  && ./obj_dir/fb_tb_sim | tee /dev/stderr | grep "PASS: all tests" > /dev/null \
  && echo "run.sh: simulation passed" \
  || { echo "run.sh: simulation failed"; exit 1; }
